/* verilog/db_pkg.sv */
`default_nettype none

package db_pkg;

    // --------------------------------------------------
    // Record geometry
    // --------------------------------------------------

    // Key width, one record per key value
    localparam int KEY_WID = 6;

    // Payload carried by each record
    localparam int VALUE_WID = 16;

    // Number of records held by the store
    localparam int NUM_RECORDS = 2 ** KEY_WID;

    // --------------------------------------------------
    // Record types
    // --------------------------------------------------

    // Key addressing exactly one record
    typedef logic [KEY_WID-1:0] key_t;

    // Value stored in a record
    typedef logic [VALUE_WID-1:0] value_t;

endpackage : db_pkg

`default_nettype wire

/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // --------------------------------------------------
    // RAM clearing machine
    // --------------------------------------------------

    // Sweeping zeros over the array, then serving requests
    typedef enum logic {
        INIT_CLEAR,
        INIT_READY
    } init_state_t;

    // --------------------------------------------------
    // Entry sizing
    // --------------------------------------------------

    // Width of one RAM entry for a record
    // Valid bit sits above the value when tracked
    function automatic int entry_wid(input bit track_valid);
        int wid;
        wid = db_pkg::VALUE_WID;
        if (track_valid) begin
            wid = wid + 1;
        end
        return wid;
    endfunction : entry_wid

endpackage : mem_pkg

`default_nettype wire

/* verilog/mem_ram_sdp.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_ram_sdp #(
    parameter int DATA_WID = mem_pkg::entry_wid(1'b1)
) (
    input  logic                clk,
    input  logic                reset,

    // Clear control
    input  logic                init,
    output logic                ready,

    // Write port
    input  logic                wr_req,
    input  db_pkg::key_t        wr_addr,
    input  logic [DATA_WID-1:0] wr_data,
    output logic                wr_ack,

    // Read port
    input  logic                rd_req,
    input  db_pkg::key_t        rd_addr,
    output logic                rd_ack,
    output logic [DATA_WID-1:0] rd_data
);
    import db_pkg::*;
    import mem_pkg::*;

    // Final address of the clearing sweep
    localparam key_t LAST_ADDR = key_t'(NUM_RECORDS - 1);

    logic                clear;
    init_state_t         state;
    key_t                clr_addr;

    logic                wr_req_q;
    key_t                wr_addr_q;
    logic [DATA_WID-1:0] wr_data_q;

    logic [DATA_WID-1:0] mem [NUM_RECORDS];

    // --------------------------------------------------
    // Clearing machine
    // --------------------------------------------------

    // Reset and init both restart the sweep
    assign clear = reset | init;

    always_ff @(posedge clk) begin
        if (clear) begin
            state    <= INIT_CLEAR;
            clr_addr <= '0;
        end else begin
            case (state)
                INIT_CLEAR: begin
                    // One entry zeroed per cycle
                    clr_addr <= clr_addr + key_t'(1);
                    if (clr_addr == LAST_ADDR) begin
                        state <= INIT_READY;
                    end
                end
                default: begin
                    state <= INIT_READY;
                end
            endcase
        end
    end

    assign ready = (state == INIT_READY);

    // --------------------------------------------------
    // Write input stage
    // --------------------------------------------------

    // Requests during the sweep are dropped
    always_ff @(posedge clk) begin
        if (clear) begin
            wr_req_q <= 1'b0;
        end else begin
            wr_req_q <= wr_req & ready;
        end
    end

    // Payload held only when a request arrives
    always_ff @(posedge clk) begin
        if (wr_req) begin
            wr_addr_q <= wr_addr;
            wr_data_q <= wr_data;
        end
    end

    // Ack in the cycle after the request
    assign wr_ack = wr_req_q;

    // --------------------------------------------------
    // Array
    // --------------------------------------------------

    // Sweep owns the write port while clearing
    always_ff @(posedge clk) begin
        if (state == INIT_CLEAR) begin
            mem[clr_addr] <= '0;
        end else if (wr_req_q) begin
            mem[wr_addr_q] <= wr_data_q;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------

    // Old contents returned on a same-edge write
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_req & ready;
        end
    end

endmodule : mem_ram_sdp

`default_nettype wire

/* verilog/db_store_array.sv */
`timescale 1ns/10ps
`default_nettype none

module db_store_array #(
    // Set to keep a valid bit with each record
    parameter bit TRACK_VALID = 1'b1
) (
    input  logic           clk,
    input  logic           reset,

    input  logic           init,
    output logic           init_done,

    // Record write
    input  logic           wr_req,
    input  db_pkg::key_t   wr_key,
    input  db_pkg::value_t wr_value,
    input  logic           wr_valid,
    output logic           wr_ack,

    // Record read
    input  logic           rd_req,
    input  db_pkg::key_t   rd_key,
    output logic           rd_ack,
    output db_pkg::value_t rd_value,
    output logic           rd_valid
);
    import mem_pkg::*;

    // RAM entry sized for value plus optional valid
    localparam int ENTRY_WID = entry_wid(TRACK_VALID);

    logic                 mem_ready;
    logic                 mem_wr_req;
    logic                 mem_rd_req;
    logic [ENTRY_WID-1:0] mem_wr_data;
    logic [ENTRY_WID-1:0] mem_rd_data;

    // --------------------------------------------------
    // Request gating
    // --------------------------------------------------

    // Nothing accepted until the array is cleared
    assign mem_wr_req = wr_req & mem_ready;
    assign mem_rd_req = rd_req & mem_ready;

    assign init_done = mem_ready;

    // --------------------------------------------------
    // Entry packing
    // --------------------------------------------------

    generate
        if (TRACK_VALID) begin : g_valid_tracked
            // Valid bit in the top of the entry
            assign mem_wr_data          = {wr_valid, wr_value};
            assign {rd_valid, rd_value} = mem_rd_data;
        end : g_valid_tracked
        else begin : g_valid_untracked
            // Value alone, every record reads as valid
            assign mem_wr_data = wr_value;
            assign rd_value    = mem_rd_data;
            assign rd_valid    = 1'b1;
        end : g_valid_untracked
    endgenerate

    // --------------------------------------------------
    // Record RAM
    // --------------------------------------------------

    mem_ram_sdp #(
        .DATA_WID ( ENTRY_WID )
    ) i_mem_ram_sdp (
        .clk     ( clk ),
        .reset   ( reset ),
        .init    ( init ),
        .ready   ( mem_ready ),
        .wr_req  ( mem_wr_req ),
        .wr_addr ( wr_key ),
        .wr_data ( mem_wr_data ),
        .wr_ack  ( wr_ack ),
        .rd_req  ( mem_rd_req ),
        .rd_addr ( rd_key ),
        .rd_ack  ( rd_ack ),
        .rd_data ( mem_rd_data )
    );

endmodule : db_store_array

`default_nettype wire

/* verilog/db_wr_stash.sv */
`timescale 1ns/10ps
`default_nettype none

module db_wr_stash (
    input  logic           clk,
    input  logic           reset,
    input  logic           init,
    input  logic           init_done,

    // Write port, seen alongside the array
    input  logic           wr_req,
    input  db_pkg::key_t   wr_key,
    input  db_pkg::value_t wr_value,
    input  logic           wr_valid,

    // Lookup by read key
    input  db_pkg::key_t   rd_key,
    output logic           hit,
    output db_pkg::value_t hit_value,
    output logic           hit_valid
);
    import db_pkg::*;

    logic   wr_accept;
    logic   cur_hit;

    // Write from the previous cycle, not yet in the array
    logic   ent_occ;
    key_t   ent_key;
    value_t ent_value;
    logic   ent_valid;
    logic   ent_hit;

    // Array takes only writes made while ready
    assign wr_accept = wr_req & init_done;

    // --------------------------------------------------
    // Stash entry
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset || init) begin
            ent_occ <= 1'b0;
        end else begin
            ent_occ <= wr_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            ent_key   <= wr_key;
            ent_value <= wr_value;
            ent_valid <= wr_valid;
        end
    end

    // --------------------------------------------------
    // Key match
    // --------------------------------------------------

    assign cur_hit = wr_accept & (wr_key == rd_key);
    assign ent_hit = ent_occ & (ent_key == rd_key);

    assign hit = cur_hit | ent_hit;

    // Current write is the youngest and wins
    assign hit_value = cur_hit ? wr_value : ent_value;
    assign hit_valid = cur_hit ? wr_valid : ent_valid;

endmodule : db_wr_stash

`default_nettype wire

/* verilog/db_rd_merge.sv */
`timescale 1ns/10ps
`default_nettype none

module db_rd_merge (
    input  logic           clk,
    input  logic           reset,

    // Stash lookup, same cycle as the read request
    input  logic           rd_req,
    input  logic           hit,
    input  db_pkg::value_t hit_value,
    input  logic           hit_valid,

    // Array read, one cycle after the request
    input  logic           arr_ack,
    input  db_pkg::value_t arr_value,
    input  logic           arr_valid,

    // Merged read result
    output logic           rd_ack,
    output db_pkg::value_t rd_value,
    output logic           rd_valid
);
    import db_pkg::*;

    logic   hit_q;
    value_t hit_value_q;
    logic   hit_valid_q;

    // --------------------------------------------------
    // Stash result alignment
    // --------------------------------------------------

    // Match flag only for real reads
    always_ff @(posedge clk) begin
        if (reset) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= rd_req & hit;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            hit_value_q <= hit_value;
            hit_valid_q <= hit_valid;
        end
    end

    // --------------------------------------------------
    // Record select
    // --------------------------------------------------

    // Stash holds newer data than the array
    assign rd_ack   = arr_ack;
    assign rd_value = hit_q ? hit_value_q : arr_value;
    assign rd_valid = hit_q ? hit_valid_q : arr_valid;

endmodule : db_rd_merge

`default_nettype wire

/* verilog/db_store.sv */
`timescale 1ns/10ps
`default_nettype none

module db_store #(
    parameter bit TRACK_VALID = 1'b1
) (
    input  logic           clk,
    input  logic           reset,

    input  logic           init,
    output logic           init_done,

    // Write port
    input  logic           wr_req,
    input  db_pkg::key_t   wr_key,
    input  db_pkg::value_t wr_value,
    input  logic           wr_valid,
    output logic           wr_ack,

    // Read port
    input  logic           rd_req,
    input  db_pkg::key_t   rd_key,
    output logic           rd_ack,
    output db_pkg::value_t rd_value,
    output logic           rd_valid
);
    import db_pkg::*;

    logic   arr_ack;
    value_t arr_value;
    logic   arr_valid;

    logic   stash_wr_valid;
    logic   hit;
    value_t hit_value;
    logic   hit_valid;

    // Untracked records always read valid
    assign stash_wr_valid = TRACK_VALID ? wr_valid : 1'b1;

    // --------------------------------------------------
    // Store array
    // --------------------------------------------------

    db_store_array #(
        .TRACK_VALID ( TRACK_VALID )
    ) i_db_store_array (
        .clk       ( clk ),
        .reset     ( reset ),
        .init      ( init ),
        .init_done ( init_done ),
        .wr_req    ( wr_req ),
        .wr_key    ( wr_key ),
        .wr_value  ( wr_value ),
        .wr_valid  ( wr_valid ),
        .wr_ack    ( wr_ack ),
        .rd_req    ( rd_req ),
        .rd_key    ( rd_key ),
        .rd_ack    ( arr_ack ),
        .rd_value  ( arr_value ),
        .rd_valid  ( arr_valid )
    );

    // --------------------------------------------------
    // Writes in flight
    // --------------------------------------------------

    db_wr_stash i_db_wr_stash (
        .clk       ( clk ),
        .reset     ( reset ),
        .init      ( init ),
        .init_done ( init_done ),
        .wr_req    ( wr_req ),
        .wr_key    ( wr_key ),
        .wr_value  ( wr_value ),
        .wr_valid  ( stash_wr_valid ),
        .rd_key    ( rd_key ),
        .hit       ( hit ),
        .hit_value ( hit_value ),
        .hit_valid ( hit_valid )
    );

    // --------------------------------------------------
    // Read result
    // --------------------------------------------------

    db_rd_merge i_db_rd_merge (
        .clk       ( clk ),
        .reset     ( reset ),
        .rd_req    ( rd_req ),
        .hit       ( hit ),
        .hit_value ( hit_value ),
        .hit_valid ( hit_valid ),
        .arr_ack   ( arr_ack ),
        .arr_value ( arr_value ),
        .arr_valid ( arr_valid ),
        .rd_ack    ( rd_ack ),
        .rd_value  ( rd_value ),
        .rd_valid  ( rd_valid )
    );

endmodule : db_store

`default_nettype wire

/* testbench/tb_db_store.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_db_store;
    import db_pkg::*;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 16;
    localparam int    INIT_CYCLES  = NUM_RECORDS;
    localparam string STIM_FILE    = "testbench/db_stimulus.txt";

    logic   clk;
    logic   reset;
    logic   init;
    logic   init_done;
    logic   wr_req;
    key_t   wr_key;
    value_t wr_value;
    logic   wr_valid;
    logic   wr_ack;
    logic   rd_req;
    key_t   rd_key;
    logic   rd_ack;
    value_t rd_value;
    logic   rd_valid;

    // Stimulus table, one entry per data line
    string  t_name      [$];
    bit     t_init      [$];
    bit     t_wr_req    [$];
    key_t   t_wr_key    [$];
    value_t t_wr_value  [$];
    bit     t_wr_valid  [$];
    bit     t_rd_req    [$];
    key_t   t_rd_key    [$];
    value_t t_exp_value [$];
    bit     t_exp_valid [$];

    int num_tests;
    int pass_count;
    int fail_count;
    bit stim_loaded;

    db_store #(
        .TRACK_VALID ( 1'b1 )
    ) i_db_store (
        .clk       ( clk ),
        .reset     ( reset ),
        .init      ( init ),
        .init_done ( init_done ),
        .wr_req    ( wr_req ),
        .wr_key    ( wr_key ),
        .wr_value  ( wr_value ),
        .wr_valid  ( wr_valid ),
        .wr_ack    ( wr_ack ),
        .rd_req    ( rd_req ),
        .rd_key    ( rd_key ),
        .rd_ack    ( rd_ack ),
        .rd_value  ( rd_value ),
        .rd_valid  ( rd_valid )
    );

    // --------------------------------------------------
    // Clock and watchdog
    // --------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Budget covers reset, two clearing sweeps and one cycle per line
    initial begin
        int limit_cycles;
        wait (stim_loaded);
        limit_cycles = RESET_CYCLES + 2 * INIT_CYCLES + num_tests + 20;
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", limit_cycles);
        $display("** FAIL **");
        $finish;
    end

    // --------------------------------------------------
    // Stimulus file
    // --------------------------------------------------

    task automatic load_stimulus();
        int    fd;
        int    code;
        string line;
        string name;
        int    f_init, f_wr_req, f_wr_key, f_wr_value, f_wr_valid;
        int    f_rd_req, f_rd_key, f_exp_value, f_exp_valid;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Stimulus file %s could not be opened", STIM_FILE);
            fail_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Skip blank and comment lines
            if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name,
                               f_init, f_wr_req, f_wr_key, f_wr_value, f_wr_valid,
                               f_rd_req, f_rd_key, f_exp_value, f_exp_valid);
                if (code == 10) begin
                    t_name.push_back(name);
                    t_init.push_back(f_init != 0);
                    t_wr_req.push_back(f_wr_req != 0);
                    t_wr_key.push_back(key_t'(f_wr_key));
                    t_wr_value.push_back(value_t'(f_wr_value));
                    t_wr_valid.push_back(f_wr_valid != 0);
                    t_rd_req.push_back(f_rd_req != 0);
                    t_rd_key.push_back(key_t'(f_rd_key));
                    t_exp_value.push_back(value_t'(f_exp_value));
                    t_exp_valid.push_back(f_exp_valid != 0);
                end else if (code > 0) begin
                    $display("Stimulus line could not be parsed: %s", line);
                    fail_count++;
                end
            end
        end
        $fclose(fd);
        num_tests = t_name.size();
    endtask

    // --------------------------------------------------
    // Drive and check helpers
    // --------------------------------------------------

    task automatic drive_idle();
        init     = 1'b0;
        wr_req   = 1'b0;
        wr_key   = '0;
        wr_value = '0;
        wr_valid = 1'b0;
        rd_req   = 1'b0;
        rd_key   = '0;
    endtask

    task automatic drive_line(input int idx);
        init     = 1'b0;
        wr_req   = t_wr_req[idx];
        wr_key   = t_wr_key[idx];
        wr_value = t_wr_value[idx];
        wr_valid = t_wr_valid[idx];
        rd_req   = t_rd_req[idx];
        rd_key   = t_rd_key[idx];
    endtask

    task automatic finish_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
            $display("test %-16s ok", name);
        end else begin
            fail_count++;
            $display("test %-16s failed", name);
        end
    endtask

    // Counts falling edges with init_done low, gives up after two sweeps
    task automatic count_init_cycles(output int cycles);
        cycles = 0;
        while (!init_done && cycles <= 2 * INIT_CYCLES) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    // Called one cycle after the line was driven
    task automatic check_line(input int idx);
        bit ok;
        ok = 1'b1;
        if (t_wr_req[idx] && !wr_ack) begin
            $display("%s: no wr_ack in the cycle after the write request", t_name[idx]);
            ok = 1'b0;
        end else if (!t_wr_req[idx] && wr_ack) begin
            $display("%s: wr_ack came without a write request", t_name[idx]);
            ok = 1'b0;
        end
        if (t_rd_req[idx]) begin
            if (!rd_ack) begin
                $display("%s: no rd_ack in the cycle after the read request", t_name[idx]);
                ok = 1'b0;
            end else begin
                if (rd_value !== t_exp_value[idx]) begin
                    $display("FAIL %s: rd_value expected %h, actual %h",
                             t_name[idx], t_exp_value[idx], rd_value);
                    ok = 1'b0;
                end
                if (rd_valid !== t_exp_valid[idx]) begin
                    $display("FAIL %s: rd_valid expected %b, actual %b",
                             t_name[idx], t_exp_valid[idx], rd_valid);
                    ok = 1'b0;
                end
            end
        end else if (rd_ack) begin
            $display("%s: rd_ack came without a read request", t_name[idx]);
            ok = 1'b0;
        end
        finish_test(t_name[idx], ok);
    endtask

    // --------------------------------------------------
    // Clearing checks
    // --------------------------------------------------

    task automatic check_reset();
        int low_cycles;
        bit ok;
        ok = 1'b1;
        // Requests held high through reset must stay unacknowledged
        wr_req   = 1'b1;
        wr_value = 16'hffff;
        wr_valid = 1'b1;
        rd_req   = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        if (init_done || wr_ack || rd_ack) begin
            $display("reset_clear: init_done, wr_ack or rd_ack high during reset");
            ok = 1'b0;
        end
        drive_idle();
        reset = 1'b0;
        count_init_cycles(low_cycles);
        if (low_cycles != INIT_CYCLES) begin
            $display("FAIL reset_clear: init_done low cycles expected %0d, actual %0d",
                     INIT_CYCLES, low_cycles);
            ok = 1'b0;
        end
        finish_test("reset_clear", ok);
    endtask

    // One-cycle init pulse, then time the sweep
    task automatic check_init_pulse(input string name);
        int low_cycles;
        bit ok;
        ok = 1'b1;
        drive_idle();
        init = 1'b1;
        @(negedge clk);
        init = 1'b0;
        count_init_cycles(low_cycles);
        if (low_cycles != INIT_CYCLES) begin
            $display("FAIL %s: init_done low cycles expected %0d, actual %0d",
                     name, INIT_CYCLES, low_cycles);
            ok = 1'b0;
        end
        finish_test(name, ok);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    task automatic run_lines();
        int pend;
        pend = -1;
        for (int i = 0; i < num_tests; i++) begin
            // Results of the previous line are stable at this edge
            if (pend >= 0) begin
                check_line(pend);
            end
            pend = -1;
            if (t_init[i]) begin
                check_init_pulse(t_name[i]);
            end else begin
                drive_line(i);
                pend = i;
                @(negedge clk);
            end
        end
        drive_idle();
        if (pend >= 0) begin
            check_line(pend);
        end
    endtask

    initial begin
        reset       = 1'b1;
        pass_count  = 0;
        fail_count  = 0;
        num_tests   = 0;
        stim_loaded = 1'b0;
        drive_idle();
        load_stimulus();
        stim_loaded = 1'b1;
        if (num_tests > 0) begin
            check_reset();
            run_lines();
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_db_store

`default_nettype wire

/* testbench/db_stimulus.txt */
# name init wr_req wr_key wr_value wr_valid rd_req rd_key exp_value exp_valid
# Numbers in hex, init line pulses init and times the sweep
blank_rd_05     0 0 00 0000 0 1 05 0000 0
blank_rd_3f     0 0 00 0000 0 1 3f 0000 0
wr_key_10       0 1 10 a5a5 1 0 00 0000 0
wr_key_11       0 1 11 1234 1 0 00 0000 0
idle_0          0 0 00 0000 0 0 00 0000 0
rd_key_10       0 0 00 0000 0 1 10 a5a5 1
rd_key_11       0 0 00 0000 0 1 11 1234 1
same_cyc_20     0 1 20 beef 1 1 20 beef 1
next_cyc_20     0 0 00 0000 0 1 20 beef 1
two_after_20    0 0 00 0000 0 1 20 beef 1
wr_a_30         0 1 30 1111 1 1 30 1111 1
wr_b_30         0 1 30 2222 1 1 30 2222 1
rd_30_young     0 0 00 0000 0 1 30 2222 1
rd_30_array     0 0 00 0000 0 1 30 2222 1
del_key_10      0 1 10 0000 0 1 10 0000 0
del_chk_10      0 0 00 0000 0 1 10 0000 0
del_arr_10      0 0 00 0000 0 1 10 0000 0
rd_key_11_again 0 0 00 0000 0 1 11 1234 1
b2b_0           0 1 01 0101 1 1 11 1234 1
b2b_1           0 1 02 0202 1 1 01 0101 1
b2b_2           0 1 03 0303 1 1 02 0202 1
b2b_3           0 1 04 0404 1 1 03 0303 1
b2b_4           0 1 05 0505 1 1 01 0101 1
b2b_5           0 1 06 0606 1 1 04 0404 1
b2b_6           0 1 07 0707 1 1 07 0707 1
b2b_7           0 1 08 0808 1 1 05 0505 1
b2b_8           0 1 09 0909 1 1 06 0606 1
b2b_9           0 0 00 0000 0 1 08 0808 1
b2b_a           0 0 00 0000 0 1 09 0909 1
init_pulse      1 0 00 0000 0 0 00 0000 0
post_rd_20      0 0 00 0000 0 1 20 0000 0
post_rd_30      0 0 00 0000 0 1 30 0000 0
post_rd_11      0 0 00 0000 0 1 11 0000 0
post_wr_3a      0 1 3a cafe 1 1 3a cafe 1
post_rd_3a      0 0 00 0000 0 1 3a cafe 1

/* compile.f */
verilog/db_pkg.sv
verilog/mem_pkg.sv
verilog/mem_ram_sdp.sv
verilog/db_store_array.sv
verilog/db_wr_stash.sv
verilog/db_rd_merge.sv
verilog/db_store.sv
testbench/tb_db_store.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the db_store testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f compile.f \
    --top-module tb_db_store \
    --Mdir obj_dir \
    -o tb_db_store

./obj_dir/tb_db_store > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
